// File: design/link_settings.svh
////////////////////////////////////////////////////////////////////////////
// Link settings
// Widths and counts shared by the logic-link slave and its testbench
////////////////////////////////////////////////////////////////////////////

`ifndef LINK_SETTINGS_SVH
`define LINK_SETTINGS_SVH

// User data word on the upstream and downstream channels
`define LINK_DATA_W 64

// One PHY lane word: marker, strobe, payload slice
`define LINK_LANE_W 44

// Payload bits carried by one lane
`define LINK_LANE_PAY_W 42

// Lanes on the die-to-die PHY
`define LINK_LANES 2

// Settle, sync and word-alignment delay values
`define LINK_DELAY_W 16

`endif

// File: design/link_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Link package
// Payload word shared by packer and unpacker, transmit phase type
////////////////////////////////////////////////////////////////////////////

`include "link_settings.svh"

package link_pkg;

  // Transmit bring-up phase
  typedef enum logic [1:0] {
    TX_OFF    = 2'd0,
    TX_SETTLE = 2'd1,
    TX_SYNC   = 2'd2,
    TX_UP     = 2'd3
  } tx_phase_e;

  // One link payload, 84 bits
  // Field view on the user side, lane view on the PHY side
  typedef union packed {
    struct packed {
      // Pad to two full lane slices, always zero
      logic [2:0]              spare;
      logic [3:0]              state;
      logic [1:0]              protid;
      logic [`LINK_DATA_W-1:0] data;
      logic                    dvalid;
      logic [7:0]              crc;
      logic                    crc_valid;
      logic                    valid;
    } fld;
    // Lane 0 takes the low slice
    logic [`LINK_LANES-1:0][`LINK_LANE_PAY_W-1:0] lane;
  } link_payload_u;

endpackage

// File: design/delay_timer.sv
////////////////////////////////////////////////////////////////////////////
// Delay timer
// Loadable down-counter, flags the last cycle of a programmed delay
// and holds the flag until it is started again
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "link_settings.svh"

module delay_timer (
  input  logic                     clk_wr,
  input  logic                     rst,
  input  logic                     start,
  input  logic [`LINK_DELAY_W-1:0] load_value,
  output logic                     expired
);

  // Cycles left in the running delay
  logic [`LINK_DELAY_W-1:0] count;
  // Set by the first start, so a cleared count does not read as expired
  logic                     armed;

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      count <= '0;
      armed <= 1'b0;
    end else if (start) begin
      // Restart overrides a running count
      count <= load_value;
      armed <= 1'b1;
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // High in the last cycle of the delay and after it
  // A load value of 0 behaves like 1
  assign expired = armed & (count <= `LINK_DELAY_W'(1));

endmodule

// File: design/link_sync_fsm.sv
////////////////////////////////////////////////////////////////////////////
// Link bring-up FSMs
// Transmit side walks off, settle, sync and up on its timer
// Receive side raises rx_up a fixed delay after rx_online
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "link_settings.svh"

module link_sync_fsm (
  input  logic                     clk_wr,
  input  logic                     rst,
  input  logic                     tx_online,
  input  logic                     rx_online,
  input  logic [`LINK_DELAY_W-1:0] delay_x_value,
  input  logic [`LINK_DELAY_W-1:0] delay_y_value,
  input  logic [`LINK_DELAY_W-1:0] delay_z_value,
  input  logic                     tx_expired,
  input  logic                     rx_expired,
  output logic                     tx_timer_start,
  output logic                     rx_timer_start,
  output logic [`LINK_DELAY_W-1:0] tx_timer_value,
  output logic [`LINK_DELAY_W-1:0] rx_timer_value,
  output link_pkg::tx_phase_e      tx_phase,
  output logic                     rx_up
);

  import link_pkg::*;

  // Previous online levels for edge detect
  logic      tx_online_q;
  logic      rx_online_q;
  logic      tx_rise;
  logic      rx_rise;
  tx_phase_e tx_phase_nxt;
  // Receive delay started and rx_online still high
  logic      rx_armed;

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_online_q <= 1'b0;
      rx_online_q <= 1'b0;
    end else begin
      tx_online_q <= tx_online;
      rx_online_q <= rx_online;
    end
  end

  assign tx_rise = tx_online & ~tx_online_q;
  assign rx_rise = rx_online & ~rx_online_q;

  //////////////////////////////////////////////////////////////////////////
  // Transmit FSM

  always_comb begin
    tx_phase_nxt   = tx_phase;
    tx_timer_start = 1'b0;
    // Settle time loads from off, sync count from settle
    tx_timer_value = (tx_phase == TX_OFF) ? delay_z_value : delay_y_value;
    if (!tx_online) begin
      // Drop back from any phase
      tx_phase_nxt = TX_OFF;
    end else begin
      case (tx_phase)
        TX_OFF: begin
          if (tx_rise) begin
            tx_phase_nxt   = TX_SETTLE;
            tx_timer_start = 1'b1;
          end
        end
        TX_SETTLE: begin
          if (tx_expired) begin
            tx_phase_nxt   = TX_SYNC;
            tx_timer_start = 1'b1;
          end
        end
        TX_SYNC: begin
          if (tx_expired) begin
            tx_phase_nxt = TX_UP;
          end
        end
        default: begin
          // Up holds until tx_online drops
          tx_phase_nxt = TX_UP;
        end
      endcase
    end
  end

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_phase <= TX_OFF;
    end else begin
      tx_phase <= tx_phase_nxt;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Receive FSM

  // Word alignment wait starts on the rising edge
  assign rx_timer_start = rx_rise;
  assign rx_timer_value = delay_x_value;

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      rx_armed <= 1'b0;
    end else begin
      rx_armed <= rx_online & (rx_armed | rx_rise);
    end
  end

  // Up from the last delay cycle on, cleared an edge after rx_online falls
  assign rx_up = rx_armed & rx_expired;

endmodule

// File: design/tx_lane_packer.sv
////////////////////////////////////////////////////////////////////////////
// Transmit lane packer
// Packs the upstream channel into two PHY lane words, adds marker
// and strobe per phase, registers both words
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "link_settings.svh"

module tx_lane_packer (
  input  logic                    clk_wr,
  input  logic                    rst,
  input  link_pkg::tx_phase_e     tx_phase,
  input  logic [3:0]              ustrm_state,
  input  logic [1:0]              ustrm_protid,
  input  logic [`LINK_DATA_W-1:0] ustrm_data,
  input  logic                    ustrm_dvalid,
  input  logic [7:0]              ustrm_crc,
  input  logic                    ustrm_crc_valid,
  input  logic                    ustrm_valid,
  input  logic [`LINK_LANES-1:0]  tx_mrk_userbit,
  input  logic                    tx_stb_userbit,
  output logic [`LINK_LANE_W-1:0] tx_phy0,
  output logic [`LINK_LANE_W-1:0] tx_phy1
);

  import link_pkg::*;

  link_payload_u                           pay;
  logic [`LINK_LANES-1:0][`LINK_LANE_W-1:0] lane_nxt;

  // Field view in, lane view out
  always_comb begin
    pay.fld.spare     = 3'b000;
    pay.fld.state     = ustrm_state;
    pay.fld.protid    = ustrm_protid;
    pay.fld.data      = ustrm_data;
    pay.fld.dvalid    = ustrm_dvalid;
    pay.fld.crc       = ustrm_crc;
    pay.fld.crc_valid = ustrm_crc_valid;
    pay.fld.valid     = ustrm_valid;
  end

  // Lane word is {marker, strobe, payload slice}
  always_comb begin
    for (int k = 0; k < `LINK_LANES; k++) begin
      case (tx_phase)
        TX_SYNC: begin
          // Strobe-only sync word
          lane_nxt[k] = {1'b0, 1'b1, {`LINK_LANE_PAY_W{1'b0}}};
        end
        TX_UP: begin
          lane_nxt[k] = {tx_mrk_userbit[k], tx_stb_userbit, pay.lane[k]};
        end
        default: begin
          // Off and settle keep the lanes quiet
          lane_nxt[k] = '0;
        end
      endcase
    end
  end

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else begin
      tx_phy0 <= lane_nxt[0];
      tx_phy1 <= lane_nxt[1];
    end
  end

endmodule

// File: design/rx_lane_unpacker.sv
////////////////////////////////////////////////////////////////////////////
// Receive lane unpacker
// Joins the payload slices of both lane words and rebuilds the
// registered downstream channel, held at zero until the receiver is up
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "link_settings.svh"

module rx_lane_unpacker (
  input  logic                    clk_wr,
  input  logic                    rst,
  input  logic                    rx_up,
  input  logic [`LINK_LANE_W-1:0] rx_phy0,
  input  logic [`LINK_LANE_W-1:0] rx_phy1,
  output logic [3:0]              dstrm_state,
  output logic [1:0]              dstrm_protid,
  output logic [`LINK_DATA_W-1:0] dstrm_data,
  output logic                    dstrm_dvalid,
  output logic [7:0]              dstrm_crc,
  output logic                    dstrm_crc_valid,
  output logic                    dstrm_valid
);

  import link_pkg::*;

  link_payload_u rx_pay;
  link_payload_u pay_q;

  // Lane view in, marker and strobe dropped
  always_comb begin
    rx_pay.lane[0] = rx_phy0[`LINK_LANE_PAY_W-1:0];
    rx_pay.lane[1] = rx_phy1[`LINK_LANE_PAY_W-1:0];
  end

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      pay_q <= '0;
    end else if (!rx_up) begin
      // Not aligned yet, nothing reaches the user
      pay_q <= '0;
    end else begin
      pay_q <= rx_pay;
    end
  end

  // Field view out, spare bits ignored
  assign dstrm_state     = pay_q.fld.state;
  assign dstrm_protid    = pay_q.fld.protid;
  assign dstrm_data      = pay_q.fld.data;
  assign dstrm_dvalid    = pay_q.fld.dvalid;
  assign dstrm_crc       = pay_q.fld.crc;
  assign dstrm_crc_valid = pay_q.fld.crc_valid;
  assign dstrm_valid     = pay_q.fld.valid;

endmodule

// File: design/lpif_link_top.sv
////////////////////////////////////////////////////////////////////////////
// Logic-link slave top
// Two-lane PHY link with auto-sync bring-up, no FIFO and no credits
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "link_settings.svh"

module lpif_link_top (
  input  logic                     clk_wr,
  input  logic                     rst,

  // Control
  input  logic                     tx_online,
  input  logic                     rx_online,
  input  logic [`LINK_DELAY_W-1:0] delay_x_value,
  input  logic [`LINK_DELAY_W-1:0] delay_y_value,
  input  logic [`LINK_DELAY_W-1:0] delay_z_value,
  input  logic [`LINK_LANES-1:0]   tx_mrk_userbit,
  input  logic                     tx_stb_userbit,

  // Upstream channel
  input  logic [3:0]               ustrm_state,
  input  logic [1:0]               ustrm_protid,
  input  logic [`LINK_DATA_W-1:0]  ustrm_data,
  input  logic                     ustrm_dvalid,
  input  logic [7:0]               ustrm_crc,
  input  logic                     ustrm_crc_valid,
  input  logic                     ustrm_valid,

  // PHY lanes
  output logic [`LINK_LANE_W-1:0]  tx_phy0,
  output logic [`LINK_LANE_W-1:0]  tx_phy1,
  input  logic [`LINK_LANE_W-1:0]  rx_phy0,
  input  logic [`LINK_LANE_W-1:0]  rx_phy1,

  // Downstream channel
  output logic [3:0]               dstrm_state,
  output logic [1:0]               dstrm_protid,
  output logic [`LINK_DATA_W-1:0]  dstrm_data,
  output logic                     dstrm_dvalid,
  output logic [7:0]               dstrm_crc,
  output logic                     dstrm_crc_valid,
  output logic                     dstrm_valid
);

  import link_pkg::*;

  //////////////////////////////////////////////////////////////////////////
  // Interconnect

  logic                     tx_timer_start;
  logic                     rx_timer_start;
  logic [`LINK_DELAY_W-1:0] tx_timer_value;
  logic [`LINK_DELAY_W-1:0] rx_timer_value;
  logic                     tx_expired;
  logic                     rx_expired;
  tx_phase_e                tx_phase;
  logic                     rx_up;

  //////////////////////////////////////////////////////////////////////////
  // Auto sync

  link_sync_fsm sync_fsm (
    .clk_wr         (clk_wr),
    .rst            (rst),
    .tx_online      (tx_online),
    .rx_online      (rx_online),
    .delay_x_value  (delay_x_value),
    .delay_y_value  (delay_y_value),
    .delay_z_value  (delay_z_value),
    .tx_expired     (tx_expired),
    .rx_expired     (rx_expired),
    .tx_timer_start (tx_timer_start),
    .rx_timer_start (rx_timer_start),
    .tx_timer_value (tx_timer_value),
    .rx_timer_value (rx_timer_value),
    .tx_phase       (tx_phase),
    .rx_up          (rx_up)
  );

  // Settle then sync count
  delay_timer tx_timer (
    .clk_wr     (clk_wr),
    .rst        (rst),
    .start      (tx_timer_start),
    .load_value (tx_timer_value),
    .expired    (tx_expired)
  );

  // Word alignment wait
  delay_timer rx_timer (
    .clk_wr     (clk_wr),
    .rst        (rst),
    .start      (rx_timer_start),
    .load_value (rx_timer_value),
    .expired    (rx_expired)
  );

  //////////////////////////////////////////////////////////////////////////
  // PHY side

  tx_lane_packer packer (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .tx_phase        (tx_phase),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .tx_mrk_userbit  (tx_mrk_userbit),
    .tx_stb_userbit  (tx_stb_userbit),
    .tx_phy0         (tx_phy0),
    .tx_phy1         (tx_phy1)
  );

  rx_lane_unpacker unpacker (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .rx_up           (rx_up),
    .rx_phy0         (rx_phy0),
    .rx_phy1         (rx_phy1),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid)
  );

endmodule

// File: sim/lpif_link_sva.sv
////////////////////////////////////////////////////////////////////////////
// Link top-level assertions
// Quiet outputs after reset and while either side is offline
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "link_settings.svh"

module lpif_link_sva (
  input logic                    clk_wr,
  input logic                    rst,
  input logic                    tx_online,
  input logic                    rx_online,
  input logic [`LINK_LANE_W-1:0] tx_phy0,
  input logic [`LINK_LANE_W-1:0] tx_phy1,
  input logic [3:0]              dstrm_state,
  input logic [1:0]              dstrm_protid,
  input logic [`LINK_DATA_W-1:0] dstrm_data,
  input logic                    dstrm_dvalid,
  input logic [7:0]              dstrm_crc,
  input logic                    dstrm_crc_valid,
  input logic                    dstrm_valid
);

  // Strobe set, marker and payload clear
  localparam logic [`LINK_LANE_W-1:0] SYNC_WORD = {2'b01, {`LINK_LANE_PAY_W{1'b0}}};

  logic dstrm_zero;

  assign dstrm_zero = (dstrm_state == '0) && (dstrm_protid == '0) && (dstrm_data == '0)
                    && !dstrm_dvalid && (dstrm_crc == '0) && !dstrm_crc_valid && !dstrm_valid;

  reset_clears_outputs: assert property (@(posedge clk_wr)
    rst |=> (tx_phy0 == '0 && tx_phy1 == '0 && dstrm_zero))
    else $error("outputs not cleared after reset");

  // Two register stages from rx_online to dstrm
  rx_offline_quiet: assert property (@(posedge clk_wr) disable iff (rst)
    !$past(rx_online, 2) |-> dstrm_zero)
    else $error("dstrm active while rx_online is low");

  // Phase and packer register between tx_online and the lanes
  tx_offline_no_sync: assert property (@(posedge clk_wr) disable iff (rst)
    !$past(tx_online, 2) |-> (tx_phy0 != SYNC_WORD && tx_phy1 != SYNC_WORD))
    else $error("sync word sent while tx_online is low");

endmodule

bind lpif_link_top lpif_link_sva sva_chk (
  .clk_wr          (clk_wr),
  .rst             (rst),
  .tx_online       (tx_online),
  .rx_online       (rx_online),
  .tx_phy0         (tx_phy0),
  .tx_phy1         (tx_phy1),
  .dstrm_state     (dstrm_state),
  .dstrm_protid    (dstrm_protid),
  .dstrm_data      (dstrm_data),
  .dstrm_dvalid    (dstrm_dvalid),
  .dstrm_crc       (dstrm_crc),
  .dstrm_crc_valid (dstrm_crc_valid),
  .dstrm_valid     (dstrm_valid)
);

// File: sim/lpif_link_tb.sv
////////////////////////////////////////////////////////////////////////////
// Logic-link slave testbench
// PHY lanes looped back, random upstream traffic, cycle model of the
// bring-up phases, lane words and downstream channel checked every cycle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "link_settings.svh"

module lpif_link_tb;

  import link_pkg::*;

  localparam int CLK_PERIOD     = 100;
  localparam int RST_CYCLES     = 5;
  localparam int IDLE_CYCLES    = 4;
  localparam int BRINGUP_CYCLES = 16;
  localparam int TRAFFIC_CYCLES = 40;
  localparam int DROP_CYCLES    = 6;
  localparam int MARGIN_CYCLES  = 20;
  // Reset, idle, two bring-ups with traffic, three drops, drain, margin
  localparam int TOTAL_CYCLES   = RST_CYCLES + IDLE_CYCLES + 2 * BRINGUP_CYCLES
                                + 2 * TRAFFIC_CYCLES + 3 * DROP_CYCLES + 2 + MARGIN_CYCLES;
  localparam int TX_W           = `LINK_LANES * `LINK_LANE_W;
  localparam int PAY_W          = `LINK_LANES * `LINK_LANE_PAY_W;
  // User fields without the spare bits
  localparam int UW_W           = `LINK_DATA_W + 17;

  logic                     clk_wr = 1'b0;
  logic                     rst;
  logic                     tx_online;
  logic                     rx_online;
  logic [`LINK_DELAY_W-1:0] delay_x_value;
  logic [`LINK_DELAY_W-1:0] delay_y_value;
  logic [`LINK_DELAY_W-1:0] delay_z_value;
  logic [`LINK_LANES-1:0]   tx_mrk_userbit;
  logic                     tx_stb_userbit;
  logic [3:0]               ustrm_state;
  logic [1:0]               ustrm_protid;
  logic [`LINK_DATA_W-1:0]  ustrm_data;
  logic                     ustrm_dvalid;
  logic [7:0]               ustrm_crc;
  logic                     ustrm_crc_valid;
  logic                     ustrm_valid;
  logic [`LINK_LANE_W-1:0]  tx_phy0;
  logic [`LINK_LANE_W-1:0]  tx_phy1;
  logic [3:0]               dstrm_state;
  logic [1:0]               dstrm_protid;
  logic [`LINK_DATA_W-1:0]  dstrm_data;
  logic                     dstrm_dvalid;
  logic [7:0]               dstrm_crc;
  logic                     dstrm_crc_valid;
  logic                     dstrm_valid;
  logic [UW_W-1:0]          ustrm_word;
  logic [UW_W-1:0]          dstrm_word;

  integer                   seed;
  int                       err_count;
  // Expected outputs pushed at the rising edge and popped at the falling edge
  logic [TX_W-1:0]          exp_tx_q[$];
  logic [UW_W-1:0]          exp_ds_q[$];

  // Cycle model state
  tx_phase_e                m_phase;
  int                       m_cnt;
  int                       m_rx_cnt;
  logic                     m_rx_up;
  logic                     m_tx_q;
  logic                     m_rx_q;
  logic [TX_W-1:0]          last_tx;

  assign ustrm_word = {ustrm_state, ustrm_protid, ustrm_data, ustrm_dvalid,
                       ustrm_crc, ustrm_crc_valid, ustrm_valid};
  assign dstrm_word = {dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid,
                       dstrm_crc, dstrm_crc_valid, dstrm_valid};

  lpif_link_top uut (
    .clk_wr (clk_wr), .rst (rst),
    .tx_online (tx_online), .rx_online (rx_online),
    .delay_x_value (delay_x_value), .delay_y_value (delay_y_value),
    .delay_z_value (delay_z_value),
    .tx_mrk_userbit (tx_mrk_userbit), .tx_stb_userbit (tx_stb_userbit),
    .ustrm_state (ustrm_state), .ustrm_protid (ustrm_protid), .ustrm_data (ustrm_data),
    .ustrm_dvalid (ustrm_dvalid), .ustrm_crc (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid), .ustrm_valid (ustrm_valid),
    .tx_phy0 (tx_phy0), .tx_phy1 (tx_phy1),
    // Loopback
    .rx_phy0 (tx_phy0), .rx_phy1 (tx_phy1),
    .dstrm_state (dstrm_state), .dstrm_protid (dstrm_protid), .dstrm_data (dstrm_data),
    .dstrm_dvalid (dstrm_dvalid), .dstrm_crc (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid), .dstrm_valid (dstrm_valid)
  );

  initial begin
    forever begin
      #(CLK_PERIOD / 2) clk_wr = ~clk_wr;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Reference and check helpers

  // Lane pair {lane1, lane0} for one phase, fields and userbits
  function automatic logic [TX_W-1:0] expected_lanes(input tx_phase_e phase,
      input logic [UW_W-1:0] uw, input logic [`LINK_LANES-1:0] mrk, input logic stb);
    logic [PAY_W-1:0] pay;
    logic [TX_W-1:0]  lanes;
    pay = '0;
    pay[UW_W-1:0] = uw;
    lanes = '0;
    for (int k = 0; k < `LINK_LANES; k++) begin
      if (phase == TX_SYNC) begin
        // Strobe only
        lanes[k*`LINK_LANE_W + `LINK_LANE_PAY_W] = 1'b1;
      end else if (phase == TX_UP) begin
        lanes[k*`LINK_LANE_W +: `LINK_LANE_W] =
          {mrk[k], stb, pay[k*`LINK_LANE_PAY_W +: `LINK_LANE_PAY_W]};
      end
    end
    return lanes;
  endfunction

  // Zero delay still spends one cycle
  function automatic int at_least_one(input logic [`LINK_DELAY_W-1:0] v);
    return (v == '0) ? 1 : int'(v);
  endfunction

  task automatic stop_on_failure();
    $display("Done: errors found");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic check_equal(input logic [TX_W-1:0] actual, input logic [TX_W-1:0] expected,
      input string what);
    if (actual !== expected) begin
      err_count++;
      $display("ERR at %0d ns: %s mismatch, got %h, expected %h",
               $time, what, actual, expected);
      stop_on_failure();
    end
  endtask

  task automatic drive_traffic();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    r0 = $random(seed);
    r1 = $random(seed);
    r2 = $random(seed);
    ustrm_data      = {r0, r1};
    ustrm_state     = r2[3:0];
    ustrm_protid    = r2[5:4];
    ustrm_dvalid    = r2[6];
    ustrm_crc       = r2[14:7];
    ustrm_crc_valid = r2[15];
    ustrm_valid     = r2[16];
    // Userbits change too
    tx_mrk_userbit  = r2[18:17];
    tx_stb_userbit  = r2[19];
  endtask

  task automatic run_cycles(input int n);
    repeat (n) begin
      @(negedge clk_wr);
      drive_traffic();
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Cycle model stepped on each rising edge

  always @(posedge clk_wr) begin
    logic [TX_W-1:0]  next_tx;
    logic [PAY_W-1:0] wire_pay;
    if (rst) begin
      m_phase  = TX_OFF;
      m_cnt    = 0;
      m_rx_cnt = 0;
      m_rx_up  = 1'b0;
      m_tx_q   = 1'b0;
      m_rx_q   = 1'b0;
      last_tx  = '0;
      exp_tx_q.push_back('0);
      exp_ds_q.push_back('0);
    end else begin
      // Lane words take the phase and inputs of this cycle
      next_tx = expected_lanes(m_phase, ustrm_word, tx_mrk_userbit, tx_stb_userbit);
      // Payload now on the looped-back lanes
      for (int k = 0; k < `LINK_LANES; k++) begin
        wire_pay[k*`LINK_LANE_PAY_W +: `LINK_LANE_PAY_W] =
          last_tx[k*`LINK_LANE_W +: `LINK_LANE_PAY_W];
      end
      exp_tx_q.push_back(next_tx);
      exp_ds_q.push_back(m_rx_up ? wire_pay[UW_W-1:0] : '0);
      last_tx = next_tx;
      // Transmit phase
      if (!tx_online) begin
        m_phase = TX_OFF;
      end else if (m_phase == TX_OFF) begin
        if (!m_tx_q) begin
          m_phase = TX_SETTLE;
          m_cnt   = at_least_one(delay_z_value);
        end
      end else if (m_phase == TX_SETTLE) begin
        m_cnt = m_cnt - 1;
        if (m_cnt == 0) begin
          m_phase = TX_SYNC;
          m_cnt   = at_least_one(delay_y_value);
        end
      end else if (m_phase == TX_SYNC) begin
        m_cnt = m_cnt - 1;
        if (m_cnt == 0) begin
          m_phase = TX_UP;
        end
      end
      // Receiver up from the last cycle of delay_x
      if (!rx_online) begin
        m_rx_up  = 1'b0;
        m_rx_cnt = 0;
      end else if (!m_rx_q) begin
        m_rx_cnt = at_least_one(delay_x_value) - 1;
        m_rx_up  = (m_rx_cnt == 0);
      end else if (m_rx_cnt > 0) begin
        m_rx_cnt = m_rx_cnt - 1;
        m_rx_up  = (m_rx_cnt == 0);
      end
      m_tx_q = tx_online;
      m_rx_q = rx_online;
    end
  end

  // Compare on the falling edge after the outputs settle
  always @(negedge clk_wr) begin
    logic [TX_W-1:0] tx_exp;
    logic [UW_W-1:0] ds_exp;
    if (exp_tx_q.size() == 0 || exp_ds_q.size() == 0) begin
      $display("No expected value was ready for the check at %0d ns", $time);
      stop_on_failure();
    end else begin
      tx_exp = exp_tx_q.pop_front();
      ds_exp = exp_ds_q.pop_front();
      check_equal({tx_phy1, tx_phy0}, tx_exp, "tx_phy lane words");
      check_equal(TX_W'(dstrm_word), TX_W'(ds_exp), "dstrm fields");
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Stimulus

  initial begin
    seed            = 77346;
    err_count       = 0;
    rst             = 1'b1;
    tx_online       = 1'b0;
    rx_online       = 1'b0;
    delay_x_value   = '0;
    delay_y_value   = '0;
    delay_z_value   = '0;
    tx_mrk_userbit  = '0;
    tx_stb_userbit  = 1'b0;
    ustrm_state     = '0;
    ustrm_protid    = '0;
    ustrm_data      = '0;
    ustrm_dvalid    = 1'b0;
    ustrm_crc       = '0;
    ustrm_crc_valid = 1'b0;
    ustrm_valid     = 1'b0;
    repeat (RST_CYCLES) @(negedge clk_wr);
    rst = 1'b0;
    // Both sides offline with lanes and downstream quiet
    run_cycles(IDLE_CYCLES);
    // First bring-up with the receiver joining once traffic flows
    delay_z_value = 16'd5;
    delay_y_value = 16'd4;
    delay_x_value = 16'd3;
    tx_online     = 1'b1;
    run_cycles(BRINGUP_CYCLES);
    rx_online = 1'b1;
    run_cycles(TRAFFIC_CYCLES);
    // Receiver drops with traffic running
    rx_online = 1'b0;
    run_cycles(DROP_CYCLES);
    tx_online = 1'b0;
    run_cycles(DROP_CYCLES);
    // Second bring-up with shortest delays on both sides together
    delay_z_value = 16'd1;
    delay_y_value = 16'd0;
    delay_x_value = 16'd0;
    tx_online     = 1'b1;
    rx_online     = 1'b1;
    run_cycles(BRINGUP_CYCLES);
    run_cycles(TRAFFIC_CYCLES);
    tx_online = 1'b0;
    rx_online = 1'b0;
    run_cycles(DROP_CYCLES);
    // Last expected entries drain
    @(negedge clk_wr);
    #(CLK_PERIOD / 4);
    if (err_count == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      stop_on_failure();
    end
  end

  // Watchdog
  initial begin
    #(TOTAL_CYCLES * CLK_PERIOD);
    $display("Timeout: the test sequence did not finish in %0d cycles", TOTAL_CYCLES);
    stop_on_failure();
  end

endmodule

// File: lpif_link_top.f
+incdir+design
design/link_pkg.sv
design/delay_timer.sv
design/link_sync_fsm.sv
design/tx_lane_packer.sv
design/rx_lane_unpacker.sv
design/lpif_link_top.sv
sim/lpif_link_sva.sv
sim/lpif_link_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the logic-link testbench with Verilator.
# The run passes only if the log holds the pass line.

set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
  --timescale 1ns/100ps \
  --top-module lpif_link_tb \
  -f lpif_link_top.f \
  -o lpif_link_sim

# The log decides, so the simulator status goes through tee
./obj_dir/lpif_link_sim 2>&1 | tee sim.log

if grep -qx "Done: no errors" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
